// File: rtl/codebook_arbiter.sv
`timescale 1ns/1ps
// fixed-priority arbiter sharing the codebook port between the loader and the decoder
module codebook_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  hd_pkg::cb_req_t     load_req,
    input  hd_pkg::cb_req_t     dec_req,
    output logic                load_gnt,
    output logic                dec_gnt,
    output hd_pkg::cb_req_t     mem_req,
    input  hd_pkg::code_entry_t mem_rdata,
    output hd_pkg::code_entry_t dec_rdata,
    output logic                dec_rd_valid
);

    logic dec_rd_pend; // a decoder read was granted last cycle

    // the loader always wins, the decoder only gets the idle port
    always_comb begin
        load_gnt = load_req.en;
        dec_gnt  = dec_req.en && !load_req.en;
        if (load_req.en) begin
            mem_req = load_req;
        end else begin
            mem_req = dec_req;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            dec_rd_pend <= 1'b0;
        end else begin
            dec_rd_pend <= dec_gnt && !dec_req.we;
        end
    end

    assign dec_rdata    = mem_rdata;   // only the decoder ever reads
    assign dec_rd_valid = dec_rd_pend;

endmodule

// File: rtl/codebook_loader.sv
`timescale 1ns/1ps
// codebook loader parsing the symbol total and the code entries out of the byte stream
module codebook_loader (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_start,
    input  logic [7:0]      byte_data,
    output logic            byte_read_en,
    output logic [31:0]     tot_chars,
    output logic [8:0]      entry_count,
    output hd_pkg::cb_req_t cb_req,
    input  logic            cb_gnt,
    output logic            load_done
);

    typedef enum logic [1:0] {st_idle, st_read, st_take, st_write} state_t;
    typedef enum logic [2:0] {f_total, f_count, f_symbol, f_len, f_path} field_t;

    state_t              state;
    field_t              field;      // which stream field the next byte belongs to
    logic [3:0]          byte_idx;   // byte position inside the total or the path
    logic [8:0]          wr_addr;
    logic [4:0]          path_bytes;
    hd_pkg::code_entry_t entry;

    // ceil(len/8) path bytes follow the length byte
    assign path_bytes = 5'((9'(entry.len) + 9'd7) >> 3);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            field       <= f_total;
            byte_idx    <= '0;
            wr_addr     <= '0;
            tot_chars   <= '0;
            entry_count <= '0;
            load_done   <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (load_start) begin
                        state    <= st_read;
                        field    <= f_total;
                        byte_idx <= '0;
                        wr_addr  <= '0;
                    end
                end
                st_read: state <= st_take; // data shows up one cycle after the pulse
                st_take: begin
                    state <= st_read;
                    case (field)
                        f_total: begin
                            tot_chars <= {tot_chars[23:0], byte_data}; // big-endian
                            byte_idx  <= byte_idx + 4'd1;
                            if (byte_idx == 4'd3) field <= f_count;
                        end
                        f_count: begin
                            entry_count <= (byte_data == 8'd0) ? 9'd256 : {1'b0, byte_data};
                            field       <= f_symbol;
                        end
                        f_symbol: field <= f_len;
                        f_len: begin
                            byte_idx <= '0;
                            field    <= f_path;
                        end
                        f_path: begin
                            byte_idx <= byte_idx + 4'd1;
                            if ({1'b0, byte_idx} + 5'd1 == path_bytes) state <= st_write;
                        end
                        default: field <= f_total;
                    endcase
                end
                st_write: begin
                    // the request stays up until the arbiter grants it
                    if (cb_gnt) begin
                        wr_addr <= wr_addr + 9'd1;
                        field   <= f_symbol;
                        if (wr_addr + 9'd1 == entry_count) begin
                            load_done <= 1'b1;
                            state     <= st_idle;
                        end else begin
                            state <= st_read;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // entry being assembled
    always_ff @(posedge clk) begin
        if (state == st_take) begin
            case (field)
                f_symbol: entry.symbol <= byte_data;
                f_len: begin
                    entry.len  <= byte_data;
                    entry.path <= '0; // unused trailing bits stay zero
                end
                f_path: entry.path[hd_pkg::path_bits-1 - 8*byte_idx -: 8] <= byte_data;
                default: ;
            endcase
        end
    end

    assign byte_read_en = (state == st_read);

    always_comb begin
        cb_req.en    = (state == st_write);
        cb_req.we    = 1'b1;
        cb_req.addr  = wr_addr[hd_pkg::cb_addr_w-1:0];
        cb_req.wdata = entry;
    end

endmodule

// File: rtl/codebook_ram.sv
`timescale 1ns/1ps
// single-port synchronous codebook memory
module codebook_ram (
    input  logic                clk,
    input  hd_pkg::cb_req_t     req,
    output hd_pkg::code_entry_t rdata
);

    hd_pkg::code_entry_t mem [hd_pkg::cb_depth];

    // a read returns the addressed entry one cycle later
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

// File: rtl/hd_control.sv
`timescale 1ns/1ps
// phase sequencer for loading and decoding with byte read routing
module hd_control (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic load_done,
    input  logic decode_done,
    input  logic load_byte_read_en,
    input  logic dec_byte_read_en,
    output logic load_start,
    output logic decode_start,
    output logic byte_read_en,
    output logic finished
);

    hd_pkg::hd_phase_t phase;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            phase        <= hd_pkg::phase_idle;
            load_start   <= 1'b0;
            decode_start <= 1'b0;
        end else begin
            load_start   <= 1'b0;
            decode_start <= 1'b0;
            case (phase)
                hd_pkg::phase_idle: begin
                    if (start) begin
                        phase      <= hd_pkg::phase_load;
                        load_start <= 1'b1;
                    end
                end
                hd_pkg::phase_load: begin
                    if (load_done) begin
                        phase        <= hd_pkg::phase_decode;
                        decode_start <= 1'b1;
                    end
                end
                hd_pkg::phase_decode: begin
                    if (decode_done) phase <= hd_pkg::phase_done;
                end
                default: phase <= hd_pkg::phase_done; // done holds until reset
            endcase
        end
    end

    // only the block owning the current phase reaches the byte source
    always_comb begin
        case (phase)
            hd_pkg::phase_load:   byte_read_en = load_byte_read_en;
            hd_pkg::phase_decode: byte_read_en = dec_byte_read_en;
            default:              byte_read_en = 1'b0;
        endcase
    end

    assign finished = (phase == hd_pkg::phase_done);

endmodule

// File: rtl/hd_decoder.sv
`timescale 1ns/1ps
// top level of the huffman decoder with loader, decoder, arbiter and codebook memory
module hd_decoder (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [7:0] byte_data,
    output logic       byte_read_en,
    output logic       out_bit,
    output logic       out_write_en,
    output logic       finished
);

    logic                load_start;
    logic                decode_start;
    logic                load_done;
    logic                decode_done;
    logic                load_byte_read_en;
    logic                dec_byte_read_en;
    logic [31:0]         tot_chars;
    logic [8:0]          entry_count;
    hd_pkg::cb_req_t     load_req;
    hd_pkg::cb_req_t     dec_req;
    hd_pkg::cb_req_t     mem_req;
    logic                load_gnt;
    logic                dec_gnt;
    hd_pkg::code_entry_t mem_rdata;
    hd_pkg::code_entry_t dec_rdata;
    logic                dec_rd_valid;

    hd_control i_control (
        .clk, .rst, .start, .load_done, .decode_done,
        .load_byte_read_en, .dec_byte_read_en,
        .load_start, .decode_start, .byte_read_en, .finished
    );

    codebook_loader i_loader (
        .clk, .rst, .load_start, .byte_data,
        .byte_read_en (load_byte_read_en),
        .tot_chars, .entry_count,
        .cb_req       (load_req),
        .cb_gnt       (load_gnt),
        .load_done
    );

    translation_decode i_translate (
        .clk, .rst, .decode_start, .tot_chars, .entry_count, .byte_data,
        .byte_read_en (dec_byte_read_en),
        .cb_req       (dec_req),
        .cb_gnt       (dec_gnt),
        .cb_rdata     (dec_rdata),
        .cb_rd_valid  (dec_rd_valid),
        .out_bit, .out_write_en, .decode_done
    );

    codebook_arbiter i_arbiter (
        .clk, .rst, .load_req, .dec_req, .load_gnt, .dec_gnt,
        .mem_req, .mem_rdata, .dec_rdata, .dec_rd_valid
    );

    codebook_ram i_ram (
        .clk,
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

// File: rtl/hd_pkg.sv
// codebook entry, memory request and phase types with the codebook size constants
package hd_pkg;

    localparam int path_bits = 128; // longest code path
    localparam int cb_depth  = 256; // number of codebook entries
    localparam int cb_addr_w = 8;

    // one codebook entry with the path left-aligned, so the first body bit is the msb
    typedef struct packed {
        logic [7:0]           symbol;
        logic [7:0]           len;  // 1 to 128
        logic [path_bits-1:0] path;
    } code_entry_t;

    // access request towards the shared codebook memory
    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [cb_addr_w-1:0] addr;
        code_entry_t          wdata;
    } cb_req_t;

    // top level phases of a decompression run
    typedef enum logic [1:0] {
        phase_idle,
        phase_load,
        phase_decode,
        phase_done
    } hd_phase_t;

endpackage

// File: rtl/translation_decode.sv
`timescale 1ns/1ps
// translation decoder matching body bits against the codebook and writing symbols serially
module translation_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_start,
    input  logic [31:0]         tot_chars,
    input  logic [8:0]          entry_count,
    input  logic [7:0]          byte_data,
    output logic                byte_read_en,
    output hd_pkg::cb_req_t     cb_req,
    input  logic                cb_gnt,
    input  hd_pkg::code_entry_t cb_rdata,
    input  logic                cb_rd_valid,
    output logic                out_bit,
    output logic                out_write_en,
    output logic                decode_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,    // byte read pulse
        st_take,     // shift one body bit into the collected path
        st_scan,     // request the next codebook entry
        st_compare,  // wait for the entry and compare it
        st_write,    // strobe the matched symbol out
        st_done
    } state_t;

    state_t                     state;
    logic                       fresh;      // byte_data holds a newly read byte
    logic [2:0]                 bits_left;  // unread bits in byte_buf
    logic [7:0]                 byte_buf;
    logic [7:0]                 cur_byte;
    logic [hd_pkg::path_bits-1:0] coll_path;
    logic [hd_pkg::path_bits-1:0] path_mask;
    logic [7:0]                 coll_len;
    logic [8:0]                 scan_addr;
    logic [31:0]                sym_cnt;
    logic [7:0]                 sym_reg;
    logic [2:0]                 wr_cnt;
    logic                       need_byte;
    logic                       hit;

    assign cur_byte  = fresh ? byte_data : byte_buf;
    assign need_byte = (bits_left == 3'd0);

    // only the leading coll_len bits of a stored path take part in the compare
    assign path_mask = ~({hd_pkg::path_bits{1'b1}} >> coll_len);
    assign hit = (cb_rdata.len == coll_len) && (((cb_rdata.path ^ coll_path) & path_mask) == '0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            fresh       <= 1'b0;
            bits_left   <= '0;
            coll_len    <= '0;
            scan_addr   <= '0;
            sym_cnt     <= '0;
            wr_cnt      <= '0;
            decode_done <= 1'b0;
        end else begin
            decode_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (decode_start) begin
                        sym_cnt   <= '0;
                        coll_len  <= '0;
                        bits_left <= '0;
                        if (tot_chars == 32'd0) begin
                            decode_done <= 1'b1; // empty body, nothing is read
                            state       <= st_done;
                        end else begin
                            state <= st_fetch;
                        end
                    end
                end
                st_fetch: begin
                    fresh <= 1'b1;
                    state <= st_take;
                end
                st_take: begin
                    fresh     <= 1'b0;
                    bits_left <= fresh ? 3'd7 : bits_left - 3'd1;
                    coll_len  <= coll_len + 8'd1;
                    scan_addr <= '0;
                    state     <= st_scan;
                end
                st_scan: begin
                    if (scan_addr == entry_count) begin
                        state <= need_byte ? st_fetch : st_take; // no entry yet, take another bit
                    end else if (cb_gnt) begin
                        state <= st_compare;
                    end
                end
                st_compare: begin
                    if (cb_rd_valid) begin
                        if (hit) begin
                            wr_cnt <= '0;
                            state  <= st_write;
                        end else begin
                            scan_addr <= scan_addr + 9'd1;
                            state     <= st_scan;
                        end
                    end
                end
                st_write: begin
                    wr_cnt <= wr_cnt + 3'd1;
                    if (wr_cnt == 3'd7) begin
                        coll_len <= '0;
                        sym_cnt  <= sym_cnt + 32'd1;
                        if (sym_cnt + 32'd1 == tot_chars) begin
                            decode_done <= 1'b1;
                            state       <= st_done;
                        end else begin
                            state <= need_byte ? st_fetch : st_take;
                        end
                    end
                end
                st_done: state <= st_done; // held until reset
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_take) begin
            byte_buf <= {cur_byte[6:0], 1'b0};
            coll_path[hd_pkg::path_bits-1 - coll_len[6:0]] <= cur_byte[7];
        end
        if (state == st_idle || (state == st_write && wr_cnt == 3'd7)) begin
            coll_path <= '0;
        end
        if (state == st_compare && cb_rd_valid && hit) begin
            sym_reg <= cb_rdata.symbol;
        end else if (state == st_write) begin
            sym_reg <= {sym_reg[6:0], 1'b0}; // msb first
        end
    end

    assign byte_read_en = (state == st_fetch);
    assign out_write_en = (state == st_write);
    assign out_bit      = (state == st_write) && sym_reg[7];

    always_comb begin
        cb_req.en    = (state == st_scan) && (scan_addr != entry_count);
        cb_req.we    = 1'b0;
        cb_req.addr  = scan_addr[hd_pkg::cb_addr_w-1:0];
        cb_req.wdata = '0;
    end

endmodule

// File: sources.f
+incdir+verification
rtl/hd_pkg.sv
rtl/codebook_ram.sv
rtl/codebook_arbiter.sv
rtl/codebook_loader.sv
rtl/translation_decode.sv
rtl/hd_control.sv
rtl/hd_decoder.sv
verification/tb_hd_decoder.sv

// File: verification/hd_stream_model.svh
// galois lfsr, canonical code builder, stream builder and reference decoder for the testbench
`ifndef hd_stream_model_svh
`define hd_stream_model_svh

// one lfsr step for every bit taken with the first bit ending up as the msb
function automatic int take_bits(input int n);
    int v;
    v = 0;
    repeat (n) begin
        v    = (v << 1) | int'(lfsr[0]);
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
endfunction

// canonical prefix codes for lengths that never decrease along the book
function automatic void build_codes();
    logic [hd_pkg::path_bits-1:0] code;
    int                           i;
    code = '0;
    for (i = 0; i < book_n; i++) begin
        if (i > 0) code = (code + 1) << (book[i].len - book[i-1].len);
        book[i].path = code << (hd_pkg::path_bits - int'(book[i].len)); // left-aligned
    end
endfunction

// symbol total, entry count and entries while put_code adds the body later
function automatic void start_stream(input logic [31:0] total);
    int i;
    int k;
    stream.delete();
    body_bits.delete();
    for (i = 3; i >= 0; i--) stream.push_back(total[8*i +: 8]);
    stream.push_back(book_n[7:0]); // a full book of 256 wraps to zero
    for (i = 0; i < book_n; i++) begin
        stream.push_back(book[i].symbol);
        stream.push_back(book[i].len);
        for (k = 0; k < (int'(book[i].len) + 7) / 8; k++) begin
            stream.push_back(book[i].path[hd_pkg::path_bits-1 - 8*k -: 8]);
        end
    end
endfunction

function automatic void put_code(input int idx);
    int j;
    for (j = 0; j < int'(book[idx].len); j++) begin
        body_bits.push_back(book[idx].path[hd_pkg::path_bits-1 - j]);
    end
endfunction

// body bytes msb first with zero fill, then pad bytes the DUT must never read
function automatic void end_stream(input int pad);
    logic [7:0] b;
    int         i;
    while (body_bits.size() % 8 != 0) body_bits.push_back(1'b0);
    for (i = 0; i < body_bits.size(); i++) begin
        b = {b[6:0], body_bits[i]};
        if (i % 8 == 7) stream.push_back(b);
    end
    body_end = stream.size();
    for (i = 0; i < pad; i++) stream.push_back(8'ha5 ^ 8'(i));
endfunction

// expected entries in output order, found by walking the body one bit at a time
function automatic void ref_decode(input int total);
    logic [hd_pkg::path_bits-1:0] coll;
    int                           n;
    int                           pos;
    int                           e;
    logic                         hit;
    expected.delete();
    coll = '0;
    n    = 0;
    pos  = 0;
    while (expected.size() < total && n < hd_pkg::path_bits && pos < body_bits.size()) begin
        coll[hd_pkg::path_bits-1 - n] = body_bits[pos];
        n++;
        pos++;
        hit = 1'b0;
        for (e = 0; e < book_n && !hit; e++) begin
            if (int'(book[e].len) == n &&
                (book[e].path >> (hd_pkg::path_bits - n)) ==
                (coll >> (hd_pkg::path_bits - n))) begin
                expected.push_back(book[e]); // the first equal entry wins
                hit = 1'b1;
            end
        end
        if (hit) begin
            coll = '0;
            n    = 0;
        end
    end
endfunction

`endif

// File: verification/tb_hd_decoder.sv
`timescale 1ns/1ps
// testbench for hd_decoder with byte source, symbol collector, compare tasks and test cases
module tb_hd_decoder;

    logic       clk;
    logic       rst;
    logic       start;
    logic [7:0] byte_data;
    logic       byte_read_en;
    logic       out_bit;
    logic       out_write_en;
    logic       finished;

    logic [31:0]         lfsr;
    hd_pkg::code_entry_t book [hd_pkg::cb_depth];
    int                  book_n;
    logic [7:0]          stream [$];    // every byte the source can hand out
    logic                body_bits [$];
    int                  body_end;      // index of the first pad byte
    hd_pkg::code_entry_t expected [$];
    int                  rd_ptr;
    int                  n_out;
    int                  strobe_n;
    logic [7:0]          sym_shift;

    `include "hd_stream_model.svh"

    hd_decoder i_dut (
        .clk, .rst, .start, .byte_data, .byte_read_en, .out_bit, .out_write_en, .finished
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_symbol(input logic [7:0] act, input hd_pkg::code_entry_t exp);
        if (act !== exp.symbol) begin
            stop_run($sformatf("FAIL at time %0t: out_bit symbol got %02h, expected %02h",
                               $time, act, exp.symbol));
        end
    endtask

    task automatic check_finished(input logic act, input logic exp);
        if (act !== exp) begin
            stop_run($sformatf("FAIL at time %0t: finished got %b, expected %b", $time, act, exp));
        end
    endtask

    // byte source that answers each read pulse with data one cycle later
    always @(posedge clk) begin
        if (rst) begin
            rd_ptr <= 0;
        end else if (byte_read_en) begin
            if (rd_ptr >= stream.size()) begin
                stop_run("a byte was read past the end of the stream");
            end else begin
                byte_data <= stream[rd_ptr];
                rd_ptr    <= rd_ptr + 1;
            end
        end
    end

    // the collector gathers eight strobes msb first into one symbol and compares it
    always @(posedge clk) begin
        if (rst) begin
            n_out    = 0;
            strobe_n = 0;
        end else if (out_write_en) begin
            sym_shift = {sym_shift[6:0], out_bit};
            strobe_n++;
            if (strobe_n == 8) begin
                strobe_n = 0;
                if (n_out >= expected.size()) begin
                    stop_run("a symbol was written beyond the symbol total");
                end else begin
                    check_symbol(sym_shift, expected[n_out]);
                    n_out++;
                end
            end
        end else if (strobe_n != 0) begin
            stop_run("a strobe group ended before 8 bits");
        end
    end

    // one full run from reset to finished, then a quiet stretch with pad bytes left
    task automatic run_case(input int total, input int limit);
        int cycles;
        int reads;
        ref_decode(total);
        if (expected.size() != total) stop_run("the reference decoder could not decode the body");
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        cycles = 0;
        while (finished !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) stop_run("timeout while waiting for finished");
        end
        if (n_out != expected.size()) stop_run("fewer symbols were written than expected");
        if (rd_ptr != body_end) stop_run("byte reads did not stop at the end of the body");
        reads = rd_ptr;
        repeat (40) begin
            @(posedge clk);
            check_finished(finished, 1'b1);
            if (rd_ptr != reads || out_write_en) begin
                stop_run("a byte read or strobe came after finished");
            end
        end
    endtask

    initial begin
        int i;
        int k;
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        byte_data = 8'h00;
        lfsr      = 32'hf909;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (20) begin
            @(posedge clk);
            check_finished(finished, 1'b0);
            if (byte_read_en || out_write_en) stop_run("a byte read or strobe came before start");
        end

        // codes 0, 10, 110 and 111 for the symbols a to d
        book_n = 4;
        for (i = 0; i < 4; i++) begin
            book[i].symbol = 8'(8'h61 + i);
            book[i].len    = (i < 2) ? 8'(i + 1) : 8'd3;
        end
        build_codes();
        start_stream(32'd10);
        for (i = 0; i < 10; i++) put_code((i * 3) % 4);
        end_stream(3);
        run_case(10, 5000);

        book_n = 16; // lengths 3 to 6, four of each
        for (i = 0; i < 16; i++) begin
            book[i].symbol = 8'(take_bits(8));
            book[i].len    = 8'(3 + i / 4);
        end
        build_codes();
        start_stream(32'd200);
        for (i = 0; i < 200; i++) put_code(take_bits(4));
        end_stream(3);
        run_case(200, 100000);

        // full book with one 9-bit path and the 128-bit path last
        book_n = hd_pkg::cb_depth;
        for (i = 0; i < book_n; i++) begin
            book[i].symbol = 8'(i);
            book[i].len    = (i < 254) ? 8'd8 : ((i == 254) ? 8'd9 : 8'd128);
        end
        build_codes();
        k = 16 + take_bits(4);
        start_stream(32'(k));
        put_code(255);
        for (i = 2; i < k; i++) put_code(take_bits(8));
        put_code(255);
        end_stream(3);
        run_case(k, 800000);

        book_n = 4; // the codebook still loads while the body stays empty
        start_stream(32'd0);
        end_stream(3);
        run_case(0, 5000);

        $display("all tests passed");
        $finish;
    end

endmodule
